//--- verilog/bank_mem_settings.svh
`ifndef BANK_MEM_SETTINGS_SVH
`define BANK_MEM_SETTINGS_SVH

// Port counts
`define NUM_WR_PORTS 2
`define NUM_RD_PORTS 2

// Bank array geometry
`define NUM_BANKS 8
`define BANK_BITS 3
`define ROW_BITS 6
`define DATA_WIDTH 32

// Banks between pipeline flops in the data chains
`define BANKS_PER_SEGMENT 4
`define NUM_SEGMENTS (`NUM_BANKS / `BANKS_PER_SEGMENT)

// Cycles from read enable to bank read data
`define SRAM_DELAY 2

// Input stage plus boundary flops plus SRAM delay
`define READ_LATENCY (1 + `NUM_SEGMENTS - 1 + `SRAM_DELAY)

`endif

//--- verilog/bank_mem_pkg.sv
`include "bank_mem_settings.svh"

package bank_mem_pkg;

  // One memory word
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // Row inside a bank
  typedef logic [`ROW_BITS-1:0] row_t;

  // Bank index
  typedef logic [`BANK_BITS-1:0] bank_t;

  // One bit per write port
  typedef logic [`NUM_WR_PORTS-1:0] wr_sel_t;

  // One bit per read port
  typedef logic [`NUM_RD_PORTS-1:0] rd_sel_t;

  // One bit per bank
  typedef logic [`NUM_BANKS-1:0] bank_mask_t;

endpackage

//--- verilog/bank_port_decode.sv
`include "bank_mem_settings.svh"

module bank_port_decode #(
  parameter int num_ports = 1
) (
  input  logic [num_ports-1:0]                  en,
  input  bank_mem_pkg::bank_t [num_ports-1:0]   bank,
  input  bank_mem_pkg::row_t [num_ports-1:0]    row,
  output bank_mem_pkg::bank_mask_t              bank_en,
  output bank_mem_pkg::row_t [`NUM_BANKS-1:0]   bank_row,
  output logic [`NUM_BANKS-1:0][num_ports-1:0]  bank_sel
);

  // Per bank, find the enabled port that addresses it
  // Later ports overwrite earlier ones so the highest port wins
  always_comb begin
    bank_en  = '0;
    bank_row = '0;
    bank_sel = '0;
    for (int b = 0; b < `NUM_BANKS; b++) begin
      for (int p = 0; p < num_ports; p++) begin
        if (en[p] && (bank[p] == bank_mem_pkg::bank_t'(b))) begin
          bank_en[b]     = 1'b1;
          bank_row[b]    = row[p];
          // Keep the mask one-hot
          bank_sel[b]    = '0;
          bank_sel[b][p] = 1'b1;
        end
      end
    end
  end

endmodule

//--- verilog/command_delay_line.sv
`include "bank_mem_settings.svh"

module command_delay_line #(
  parameter int sel_bits = 1
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  bank_mem_pkg::bank_mask_t              bank_en,
  input  bank_mem_pkg::row_t [`NUM_BANKS-1:0]   bank_row,
  input  logic [`NUM_BANKS-1:0][sel_bits-1:0]   bank_sel,
  output bank_mem_pkg::bank_mask_t              staged_en,
  output bank_mem_pkg::row_t [`NUM_BANKS-1:0]   staged_row,
  output logic [`NUM_BANKS-1:0][sel_bits-1:0]   staged_sel
);

  // Stage s holds commands that are 1+s cycles old
  bank_mem_pkg::bank_mask_t             en_q  [`NUM_SEGMENTS];
  bank_mem_pkg::row_t [`NUM_BANKS-1:0]  row_q [`NUM_SEGMENTS];
  logic [`NUM_BANKS-1:0][sel_bits-1:0]  sel_q [`NUM_SEGMENTS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `NUM_SEGMENTS; s++) begin
        en_q[s]  <= '0;
        sel_q[s] <= '0;
      end
    end else begin
      en_q[0]  <= bank_en;
      sel_q[0] <= bank_sel;
      for (int s = 1; s < `NUM_SEGMENTS; s++) begin
        en_q[s]  <= en_q[s-1];
        sel_q[s] <= sel_q[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    row_q[0] <= bank_row;
    for (int s = 1; s < `NUM_SEGMENTS; s++) begin
      row_q[s] <= row_q[s-1];
    end
  end

  // Farther banks tap later stages
  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_tap
    localparam int seg_idx = b / `BANKS_PER_SEGMENT;
    assign staged_en[b]  = en_q[seg_idx][b];
    assign staged_row[b] = row_q[seg_idx][b];
    assign staged_sel[b] = sel_q[seg_idx][b];
  end

endmodule

//--- verilog/write_data_chain.sv
`include "bank_mem_settings.svh"

module write_data_chain (
  input  logic                                      clk,
  input  bank_mem_pkg::data_t [`NUM_WR_PORTS-1:0]   wr_data,
  input  bank_mem_pkg::wr_sel_t [`NUM_BANKS-1:0]    staged_sel,
  output bank_mem_pkg::data_t [`NUM_BANKS-1:0]      bank_wdata
);

  // Input stage lines data up with the first command stage
  bank_mem_pkg::data_t [`NUM_WR_PORTS-1:0] wr_q;

  // chain[b] is the port vector seen by bank b
  bank_mem_pkg::data_t [`NUM_WR_PORTS-1:0] chain [`NUM_BANKS];

  always_ff @(posedge clk) begin
    wr_q <= wr_data;
  end

  assign chain[0] = wr_q;

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
    localparam bit boundary = ((b % `BANKS_PER_SEGMENT) == (`BANKS_PER_SEGMENT - 1)) &&
                              (b != (`NUM_BANKS - 1));

    bank_mem_pkg::data_t word;

    // Pick the word of the port that owns this bank
    always_comb begin
      word = '0;
      for (int p = 0; p < `NUM_WR_PORTS; p++) begin
        if (staged_sel[b][p]) begin
          word = word | chain[b][p];
        end
      end
    end

    assign bank_wdata[b] = word;

    if (boundary) begin : g_flop
      bank_mem_pkg::data_t [`NUM_WR_PORTS-1:0] seg_q;

      always_ff @(posedge clk) begin
        seg_q <= chain[b];
      end

      assign chain[b+1] = seg_q;
    end else if (b < `NUM_BANKS - 1) begin : g_pass
      assign chain[b+1] = chain[b];
    end
  end

endmodule

//--- verilog/bank_sram.sv
`include "bank_mem_settings.svh"

module bank_sram (
  input  logic                                  clk,
  input  bank_mem_pkg::bank_mask_t              wr_bank_en,
  input  bank_mem_pkg::row_t [`NUM_BANKS-1:0]   wr_bank_row,
  input  bank_mem_pkg::data_t [`NUM_BANKS-1:0]  bank_wdata,
  input  bank_mem_pkg::bank_mask_t              rd_bank_en,
  input  bank_mem_pkg::row_t [`NUM_BANKS-1:0]   rd_bank_row,
  output bank_mem_pkg::data_t [`NUM_BANKS-1:0]  bank_rdata
);

  localparam int num_rows = 2 ** `ROW_BITS;

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
    bank_mem_pkg::data_t mem [num_rows];

    // Read data pipeline, last stage drives the bank output
    bank_mem_pkg::data_t rd_pipe [`SRAM_DELAY];

    always_ff @(posedge clk) begin
      if (wr_bank_en[b]) begin
        mem[wr_bank_row[b]] <= bank_wdata[b];
      end
    end

    // Same-edge write is not seen here, the old word is captured
    always_ff @(posedge clk) begin
      if (rd_bank_en[b]) begin
        rd_pipe[0] <= mem[rd_bank_row[b]];
      end
      for (int i = 1; i < `SRAM_DELAY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end

    assign bank_rdata[b] = rd_pipe[`SRAM_DELAY-1];
  end

endmodule

//--- verilog/read_data_chain.sv
`include "bank_mem_settings.svh"

module read_data_chain (
  input  logic                                      clk,
  input  logic                                      rst,
  input  bank_mem_pkg::rd_sel_t [`NUM_BANKS-1:0]    staged_sel,
  input  bank_mem_pkg::data_t [`NUM_BANKS-1:0]      bank_rdata,
  output bank_mem_pkg::data_t [`NUM_RD_PORTS-1:0]   rd_data
);

  // Read masks follow the bank data through the SRAM delay
  bank_mem_pkg::rd_sel_t [`NUM_BANKS-1:0] mask_q [`SRAM_DELAY];

  // chain[b] holds each port's word as it enters bank b
  bank_mem_pkg::data_t [`NUM_RD_PORTS-1:0] chain [`NUM_BANKS+1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `SRAM_DELAY; i++) begin
        mask_q[i] <= '0;
      end
    end else begin
      mask_q[0] <= staged_sel;
      for (int i = 1; i < `SRAM_DELAY; i++) begin
        mask_q[i] <= mask_q[i-1];
      end
    end
  end

  assign chain[0] = '0;

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
    localparam bit boundary = ((b % `BANKS_PER_SEGMENT) == (`BANKS_PER_SEGMENT - 1)) &&
                              (b != (`NUM_BANKS - 1));

    bank_mem_pkg::data_t [`NUM_RD_PORTS-1:0] merged;

    // Selected bank replaces the passing word
    always_comb begin
      for (int p = 0; p < `NUM_RD_PORTS; p++) begin
        if (mask_q[`SRAM_DELAY-1][b][p]) begin
          merged[p] = bank_rdata[b];
        end else begin
          merged[p] = chain[b][p];
        end
      end
    end

    if (boundary) begin : g_flop
      bank_mem_pkg::data_t [`NUM_RD_PORTS-1:0] seg_q;

      always_ff @(posedge clk) begin
        seg_q <= merged;
      end

      assign chain[b+1] = seg_q;
    end else begin : g_pass
      assign chain[b+1] = merged;
    end
  end

  assign rd_data = chain[`NUM_BANKS];

endmodule

//--- verilog/read_tag_pipe.sv
`include "bank_mem_settings.svh"

module read_tag_pipe (
  input  logic                                                clk,
  input  logic                                                rst,
  input  bank_mem_pkg::rd_sel_t                               rd_en,
  input  bank_mem_pkg::bank_t [`NUM_RD_PORTS-1:0]             rd_bank,
  input  bank_mem_pkg::row_t [`NUM_RD_PORTS-1:0]              rd_row,
  output bank_mem_pkg::rd_sel_t                               rd_valid,
  output logic [`NUM_RD_PORTS-1:0][`BANK_BITS+`ROW_BITS-1:0]  rd_addr
);

  bank_mem_pkg::rd_sel_t                              valid_q [`READ_LATENCY];
  logic [`NUM_RD_PORTS-1:0][`BANK_BITS+`ROW_BITS-1:0] addr_q  [`READ_LATENCY];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `READ_LATENCY; i++) begin
        valid_q[i] <= '0;
      end
    end else begin
      valid_q[0] <= rd_en;
      for (int i = 1; i < `READ_LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Address echoed as bank above row
  always_ff @(posedge clk) begin
    for (int p = 0; p < `NUM_RD_PORTS; p++) begin
      addr_q[0][p] <= {rd_bank[p], rd_row[p]};
    end
    for (int i = 1; i < `READ_LATENCY; i++) begin
      addr_q[i] <= addr_q[i-1];
    end
  end

  assign rd_valid = valid_q[`READ_LATENCY-1];
  assign rd_addr  = addr_q[`READ_LATENCY-1];

endmodule

//--- verilog/multiport_bank_mem.sv
`include "bank_mem_settings.svh"

module multiport_bank_mem (
  input  logic                                                clk,
  input  logic                                                rst,
  input  bank_mem_pkg::wr_sel_t                               wr_en,
  input  bank_mem_pkg::bank_t [`NUM_WR_PORTS-1:0]             wr_bank,
  input  bank_mem_pkg::row_t [`NUM_WR_PORTS-1:0]              wr_row,
  input  bank_mem_pkg::data_t [`NUM_WR_PORTS-1:0]             wr_data,
  input  bank_mem_pkg::rd_sel_t                               rd_en,
  input  bank_mem_pkg::bank_t [`NUM_RD_PORTS-1:0]             rd_bank,
  input  bank_mem_pkg::row_t [`NUM_RD_PORTS-1:0]              rd_row,
  output bank_mem_pkg::rd_sel_t                               rd_valid,
  output logic [`NUM_RD_PORTS-1:0][`BANK_BITS+`ROW_BITS-1:0]  rd_addr,
  output bank_mem_pkg::data_t [`NUM_RD_PORTS-1:0]             rd_data
);

  // Decoded commands, before staging
  bank_mem_pkg::bank_mask_t                   wr_dec_en;
  bank_mem_pkg::row_t [`NUM_BANKS-1:0]        wr_dec_row;
  bank_mem_pkg::wr_sel_t [`NUM_BANKS-1:0]     wr_dec_sel;
  bank_mem_pkg::bank_mask_t                   rd_dec_en;
  bank_mem_pkg::row_t [`NUM_BANKS-1:0]        rd_dec_row;
  bank_mem_pkg::rd_sel_t [`NUM_BANKS-1:0]     rd_dec_sel;

  // Commands as each bank sees them
  bank_mem_pkg::bank_mask_t                   wr_bank_en;
  bank_mem_pkg::row_t [`NUM_BANKS-1:0]        wr_bank_row;
  bank_mem_pkg::wr_sel_t [`NUM_BANKS-1:0]     wr_bank_sel;
  bank_mem_pkg::bank_mask_t                   rd_bank_en;
  bank_mem_pkg::row_t [`NUM_BANKS-1:0]        rd_bank_row;
  bank_mem_pkg::rd_sel_t [`NUM_BANKS-1:0]     rd_bank_sel;

  bank_mem_pkg::data_t [`NUM_BANKS-1:0]       bank_wdata;
  bank_mem_pkg::data_t [`NUM_BANKS-1:0]       bank_rdata;

  bank_port_decode #(
    .num_ports (`NUM_WR_PORTS)
  ) u_wr_decode (
    .en       (wr_en),
    .bank     (wr_bank),
    .row      (wr_row),
    .bank_en  (wr_dec_en),
    .bank_row (wr_dec_row),
    .bank_sel (wr_dec_sel)
  );

  bank_port_decode #(
    .num_ports (`NUM_RD_PORTS)
  ) u_rd_decode (
    .en       (rd_en),
    .bank     (rd_bank),
    .row      (rd_row),
    .bank_en  (rd_dec_en),
    .bank_row (rd_dec_row),
    .bank_sel (rd_dec_sel)
  );

  command_delay_line #(
    .sel_bits (`NUM_WR_PORTS)
  ) u_wr_stage (
    .clk        (clk),
    .rst        (rst),
    .bank_en    (wr_dec_en),
    .bank_row   (wr_dec_row),
    .bank_sel   (wr_dec_sel),
    .staged_en  (wr_bank_en),
    .staged_row (wr_bank_row),
    .staged_sel (wr_bank_sel)
  );

  command_delay_line #(
    .sel_bits (`NUM_RD_PORTS)
  ) u_rd_stage (
    .clk        (clk),
    .rst        (rst),
    .bank_en    (rd_dec_en),
    .bank_row   (rd_dec_row),
    .bank_sel   (rd_dec_sel),
    .staged_en  (rd_bank_en),
    .staged_row (rd_bank_row),
    .staged_sel (rd_bank_sel)
  );

  write_data_chain u_write_data_chain (
    .clk        (clk),
    .wr_data    (wr_data),
    .staged_sel (wr_bank_sel),
    .bank_wdata (bank_wdata)
  );

  bank_sram u_bank_sram (
    .clk         (clk),
    .wr_bank_en  (wr_bank_en),
    .wr_bank_row (wr_bank_row),
    .bank_wdata  (bank_wdata),
    .rd_bank_en  (rd_bank_en),
    .rd_bank_row (rd_bank_row),
    .bank_rdata  (bank_rdata)
  );

  read_data_chain u_read_data_chain (
    .clk        (clk),
    .rst        (rst),
    .staged_sel (rd_bank_sel),
    .bank_rdata (bank_rdata),
    .rd_data    (rd_data)
  );

  read_tag_pipe u_read_tag_pipe (
    .clk      (clk),
    .rst      (rst),
    .rd_en    (rd_en),
    .rd_bank  (rd_bank),
    .rd_row   (rd_row),
    .rd_valid (rd_valid),
    .rd_addr  (rd_addr)
  );

endmodule

//--- tests/multiport_bank_mem_asserts.sv
`include "bank_mem_settings.svh"

module multiport_bank_mem_asserts (
  input logic                                     clk,
  input logic                                     rst,
  input bank_mem_pkg::wr_sel_t                    wr_en,
  input bank_mem_pkg::bank_t [`NUM_WR_PORTS-1:0]  wr_bank,
  input bank_mem_pkg::rd_sel_t                    rd_en,
  input bank_mem_pkg::bank_t [`NUM_RD_PORTS-1:0]  rd_bank,
  input bank_mem_pkg::rd_sel_t                    rd_valid
);

  logic wr_conflict;
  logic rd_conflict;

  // Two enabled ports on one bank
  always_comb begin
    wr_conflict = 1'b0;
    rd_conflict = 1'b0;
    for (int i = 0; i < `NUM_WR_PORTS; i++) begin
      for (int j = i + 1; j < `NUM_WR_PORTS; j++) begin
        if (wr_en[i] && wr_en[j] && wr_bank[i] == wr_bank[j]) begin
          wr_conflict = 1'b1;
        end
      end
    end
    for (int i = 0; i < `NUM_RD_PORTS; i++) begin
      for (int j = i + 1; j < `NUM_RD_PORTS; j++) begin
        if (rd_en[i] && rd_en[j] && rd_bank[i] == rd_bank[j]) begin
          rd_conflict = 1'b1;
        end
      end
    end
  end

  wr_banks_distinct: assert property (@(posedge clk) disable iff (rst) !wr_conflict)
    else $error("two write ports address the same bank");

  rd_banks_distinct: assert property (@(posedge clk) disable iff (rst) !rd_conflict)
    else $error("two read ports address the same bank");

  rd_valid_timing: assert property (@(posedge clk) disable iff (rst)
                                    rd_valid == $past(rd_en, `READ_LATENCY))
    else $error("rd_valid does not follow rd_en by the read latency");

endmodule

bind multiport_bank_mem multiport_bank_mem_asserts u_asserts (
  .clk      (clk),
  .rst      (rst),
  .wr_en    (wr_en),
  .wr_bank  (wr_bank),
  .rd_en    (rd_en),
  .rd_bank  (rd_bank),
  .rd_valid (rd_valid)
);

//--- tests/multiport_bank_mem_tb.sv
`include "bank_mem_settings.svh"

module multiport_bank_mem_tb;

  localparam int num_rows     = 1 << `ROW_BITS;
  localparam int num_addrs    = `NUM_BANKS * num_rows;
  localparam int conc_cycles  = 256;
  localparam int hazard_pairs = 16;
  localparam int rand_cycles  = 2000;
  localparam int rst_traffic  = 40;
  localparam int total_cycles = 10 + 20 + 4 * num_addrs + conc_cycles + 2 * hazard_pairs +
                                rand_cycles + 2 * rst_traffic + 100;

  typedef struct packed {
    int unsigned         due;
    int                  port;
    bank_mem_pkg::bank_t bank;
    bank_mem_pkg::row_t  row;
    bank_mem_pkg::data_t data;
  } expected_t;

  logic                                                clk;
  logic                                                rst;
  bank_mem_pkg::wr_sel_t                               wr_en;
  bank_mem_pkg::bank_t [`NUM_WR_PORTS-1:0]             wr_bank;
  bank_mem_pkg::row_t [`NUM_WR_PORTS-1:0]              wr_row;
  bank_mem_pkg::data_t [`NUM_WR_PORTS-1:0]             wr_data;
  bank_mem_pkg::rd_sel_t                               rd_en;
  bank_mem_pkg::bank_t [`NUM_RD_PORTS-1:0]             rd_bank;
  bank_mem_pkg::row_t [`NUM_RD_PORTS-1:0]              rd_row;
  bank_mem_pkg::rd_sel_t                               rd_valid;
  logic [`NUM_RD_PORTS-1:0][`BANK_BITS+`ROW_BITS-1:0]  rd_addr;
  bank_mem_pkg::data_t [`NUM_RD_PORTS-1:0]             rd_data;

  // Shadow copy of the bank array and results still in flight
  bank_mem_pkg::data_t shadow [`NUM_BANKS][num_rows];
  expected_t           pending [$];
  int unsigned         edge_cnt = 0;

  multiport_bank_mem i_multiport_bank_mem (
    .clk      (clk),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_bank  (wr_bank),
    .wr_row   (wr_row),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .rd_bank  (rd_bank),
    .rd_row   (rd_row),
    .rd_valid (rd_valid),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  task automatic report_failure(string why);
    $display("STATUS: FAIL");
    $fatal(1, "%s", why);
  endtask

  initial begin
    #((total_cycles + 100) * 20);
    $display("Timeout: the test sequence did not finish in time");
    report_failure("watchdog expired");
  end

  // Old word of the shadow memory before this cycle's writes
  function automatic bank_mem_pkg::data_t expected_read(bank_mem_pkg::bank_t b,
                                                        bank_mem_pkg::row_t r);
    return shadow[b][r];
  endfunction

  task automatic check_valid(bank_mem_pkg::rd_sel_t got, bank_mem_pkg::rd_sel_t exp);
    if (got !== exp) begin
      $display("error %0t: rd_valid is %b, expected %b", $time, got, exp);
      report_failure("rd_valid mismatch");
    end
  endtask

  task automatic check_addr(int port, bank_mem_pkg::bank_t got_bank, bank_mem_pkg::row_t got_row,
                            bank_mem_pkg::bank_t exp_bank, bank_mem_pkg::row_t exp_row);
    if (got_bank !== exp_bank || got_row !== exp_row) begin
      $display("error %0t: port %0d rd_addr is %0d/%0d, expected %0d/%0d", $time, port,
               got_bank, got_row, exp_bank, exp_row);
      report_failure("rd_addr mismatch");
    end
  endtask

  task automatic check_data(int port, bank_mem_pkg::data_t got, bank_mem_pkg::data_t exp);
    if (got !== exp) begin
      $display("error %0t: port %0d rd_data is %h, expected %h", $time, port, got, exp);
      report_failure("rd_data mismatch");
    end
  endtask

  // Outputs for edge edge_cnt+1 are stable at the falling edge before it
  task automatic compare_outputs();
    bank_mem_pkg::rd_sel_t exp_valid;
    expected_t             exp_port [`NUM_RD_PORTS];
    expected_t             e;
    exp_valid = '0;
    while (pending.size() > 0 && pending[0].due <= edge_cnt + 1) begin
      e = pending.pop_front();
      if (e.due != edge_cnt + 1) begin
        $display("A read result for port %0d was skipped", e.port);
        report_failure("read result skipped");
      end
      exp_valid[e.port] = 1'b1;
      exp_port[e.port]  = e;
    end
    check_valid(rd_valid, exp_valid);
    for (int p = 0; p < `NUM_RD_PORTS; p++) begin
      if (exp_valid[p]) begin
        check_addr(p, rd_addr[p][`BANK_BITS+`ROW_BITS-1:`ROW_BITS], rd_addr[p][`ROW_BITS-1:0],
                   exp_port[p].bank, exp_port[p].row);
        check_data(p, rd_data[p], exp_port[p].data);
      end
    end
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (edge_cnt >= 1) begin
        compare_outputs();
      end
    end
  end

  task automatic next_slot();
    @(posedge clk);
    #2;
  endtask

  task automatic clear_commands();
    wr_en   = '0;
    wr_bank = '0;
    wr_row  = '0;
    wr_data = '0;
    rd_en   = '0;
    rd_bank = '0;
    rd_row  = '0;
  endtask

  // Log the commands driven in this slot into the reference model
  task automatic commit_cycle();
    expected_t e;
    for (int i = 0; i < `NUM_WR_PORTS; i++) begin
      for (int j = i + 1; j < `NUM_WR_PORTS; j++) begin
        if (wr_en[i] && wr_en[j] && wr_bank[i] == wr_bank[j]) begin
          report_failure("stimulus put two writes on one bank in a cycle");
        end
      end
    end
    for (int i = 0; i < `NUM_RD_PORTS; i++) begin
      for (int j = i + 1; j < `NUM_RD_PORTS; j++) begin
        if (rd_en[i] && rd_en[j] && rd_bank[i] == rd_bank[j]) begin
          report_failure("stimulus put two reads on one bank in a cycle");
        end
      end
    end
    for (int p = 0; p < `NUM_RD_PORTS; p++) begin
      if (rd_en[p]) begin
        e.due  = edge_cnt + 1 + `READ_LATENCY;
        e.port = p;
        e.bank = rd_bank[p];
        e.row  = rd_row[p];
        e.data = expected_read(rd_bank[p], rd_row[p]);
        pending.push_back(e);
      end
    end
    for (int p = 0; p < `NUM_WR_PORTS; p++) begin
      if (wr_en[p]) begin
        shadow[wr_bank[p]][wr_row[p]] = wr_data[p];
      end
    end
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      next_slot();
      clear_commands();
      commit_cycle();
    end
  endtask

  task automatic write_all_rows();
    for (int wp = 0; wp < `NUM_WR_PORTS; wp++) begin
      for (int a = 0; a < num_addrs; a++) begin
        next_slot();
        clear_commands();
        wr_en[wp]   = 1'b1;
        wr_bank[wp] = bank_mem_pkg::bank_t'(a / num_rows);
        wr_row[wp]  = bank_mem_pkg::row_t'(a % num_rows);
        wr_data[wp] = bank_mem_pkg::data_t'($urandom);
        commit_cycle();
      end
      // Read ports sweep the array half an array apart
      for (int a = 0; a < num_addrs; a++) begin
        next_slot();
        clear_commands();
        for (int rp = 0; rp < `NUM_RD_PORTS; rp++) begin
          rd_en[rp]   = 1'b1;
          rd_bank[rp] = bank_mem_pkg::bank_t'((a / num_rows + rp * `BANKS_PER_SEGMENT) %
                                              `NUM_BANKS);
          rd_row[rp]  = bank_mem_pkg::row_t'(a % num_rows);
        end
        commit_cycle();
      end
    end
  endtask

  task automatic concurrent_traffic();
    for (int i = 0; i < conc_cycles; i++) begin
      next_slot();
      clear_commands();
      wr_en      = '1;
      rd_en      = '1;
      wr_bank[0] = bank_mem_pkg::bank_t'(i % 4);
      wr_bank[1] = bank_mem_pkg::bank_t'(4 + (i + 1) % 4);
      rd_bank[0] = bank_mem_pkg::bank_t'(4 + i % 4);
      rd_bank[1] = bank_mem_pkg::bank_t'((i + 2) % 4);
      for (int p = 0; p < 2; p++) begin
        wr_row[p]  = bank_mem_pkg::row_t'($urandom_range(num_rows - 1, 0));
        wr_data[p] = bank_mem_pkg::data_t'($urandom);
        rd_row[p]  = bank_mem_pkg::row_t'($urandom_range(num_rows - 1, 0));
      end
      commit_cycle();
    end
  endtask

  // Same-edge read sees the old word and the next read sees the new word
  task automatic read_write_hazard();
    bank_mem_pkg::bank_t hb;
    bank_mem_pkg::row_t  hr;
    for (int k = 0; k < hazard_pairs; k++) begin
      hb = bank_mem_pkg::bank_t'(k % `NUM_BANKS);
      hr = bank_mem_pkg::row_t'($urandom_range(num_rows - 1, 0));
      next_slot();
      clear_commands();
      wr_en[0]   = 1'b1;
      wr_bank[0] = hb;
      wr_row[0]  = hr;
      wr_data[0] = ~expected_read(hb, hr);
      rd_en[0]   = 1'b1;
      rd_bank[0] = hb;
      rd_row[0]  = hr;
      commit_cycle();
      next_slot();
      clear_commands();
      rd_en[0]   = 1'b1;
      rd_bank[0] = hb;
      rd_row[0]  = hr;
      commit_cycle();
    end
  endtask

  task automatic random_cycle(bit allow_writes);
    bank_mem_pkg::bank_mask_t used;
    bank_mem_pkg::bank_t      b;
    next_slot();
    clear_commands();
    used = '0;
    for (int p = 0; p < `NUM_WR_PORTS; p++) begin
      do begin
        b = bank_mem_pkg::bank_t'($urandom_range(`NUM_BANKS - 1, 0));
      end while (used[b]);
      used[b]    = 1'b1;
      wr_en[p]   = allow_writes && ($urandom_range(1, 0) != 0);
      wr_bank[p] = b;
      wr_row[p]  = bank_mem_pkg::row_t'($urandom_range(num_rows - 1, 0));
      wr_data[p] = bank_mem_pkg::data_t'($urandom);
    end
    used = '0;
    for (int p = 0; p < `NUM_RD_PORTS; p++) begin
      do begin
        b = bank_mem_pkg::bank_t'($urandom_range(`NUM_BANKS - 1, 0));
      end while (used[b]);
      used[b]    = 1'b1;
      rd_en[p]   = ($urandom_range(1, 0) != 0);
      rd_bank[p] = b;
      rd_row[p]  = bank_mem_pkg::row_t'($urandom_range(num_rows - 1, 0));
    end
    commit_cycle();
  endtask

  task automatic reset_mid_traffic();
    for (int i = 0; i < rst_traffic; i++) begin
      random_cycle(1'b0);
    end
    next_slot();
    clear_commands();
    rst = 1'b1;
    // Results due after the reset edge are cleared in the DUT
    while (pending.size() > 0 && pending[$].due > edge_cnt + 1) begin
      void'(pending.pop_back());
    end
    repeat (5) begin
      next_slot();
      clear_commands();
    end
    next_slot();
    rst = 1'b0;
    idle_cycles(8);
    for (int i = 0; i < rst_traffic; i++) begin
      random_cycle(1'b0);
    end
  endtask

  initial begin
    void'($urandom(52290));
    rst = 1'b1;
    clear_commands();
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    idle_cycles(20);
    write_all_rows();
    idle_cycles(10);
    concurrent_traffic();
    idle_cycles(10);
    read_write_hazard();
    idle_cycles(10);
    for (int i = 0; i < rand_cycles; i++) begin
      random_cycle(1'b1);
    end
    idle_cycles(10);
    reset_mid_traffic();
    idle_cycles(10);
    if (pending.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      report_failure("read results missing at the end of the run");
    end
  end

endmodule

//--- multiport_bank_mem.f
+incdir+verilog
verilog/bank_mem_pkg.sv
verilog/bank_port_decode.sv
verilog/command_delay_line.sv
verilog/write_data_chain.sv
verilog/bank_sram.sv
verilog/read_data_chain.sv
verilog/read_tag_pipe.sv
verilog/multiport_bank_mem.sv
tests/multiport_bank_mem_asserts.sv
tests/multiport_bank_mem_tb.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module multiport_bank_mem_tb \
  -f multiport_bank_mem.f \
  -o multiport_bank_mem_sim

./obj_dir/multiport_bank_mem_sim 2>&1 | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
  exit 0
else
  exit 1
fi
